// ==== logic/bulls_pkg.sv ====
`default_nettype none

package bulls_pkg;

    localparam int DIGITS       = 4;
    localparam int DIGIT_W      = 4;
    localparam int SEG_W        = 7;
    localparam int DEBOUNCE_LEN = 4;
    localparam int SCAN_W       = 6;  // Top two bits pick the lit digit

    localparam logic [15:0] LFSR_SEED = 16'b1011_1101_1010_0101;

    typedef logic [DIGIT_W-1:0] digit_t;
    typedef digit_t [DIGITS-1:0] code_t;  // Slot 0 in the low nibble
    typedef logic [SEG_W-1:0] seg_t;      // Active low, a in bit 6

    localparam digit_t MAX_DIGIT = 4'd9;

    typedef struct packed {
        logic [2:0] bulls;
        logic [2:0] cows;
    } score_t;

    typedef struct packed {
        logic start;
        logic enter;
    } buttons_t;

    typedef enum logic [2:0] {
        title,
        guess_entry,
        check,
        decision,
        new_round
    } game_state_e;

    // Entry 15 first
    localparam seg_t [15:0] SEG_DIGIT = {
        7'b0111000, 7'b0110000, 7'b1000010, 7'b0110001,  // F E D C
        7'b1100000, 7'b0001000, 7'b0000100, 7'b0000000,  // B A 9 8
        7'b0001111, 7'b0100000, 7'b0100100, 7'b1001100,  // 7 6 5 4
        7'b0000110, 7'b0010010, 7'b1001111, 7'b0000001   // 3 2 1 0
    };

    localparam seg_t SEG_A     = 7'b0001000;
    localparam seg_t SEG_B     = 7'b1100000;
    localparam seg_t SEG_BLANK = 7'b1111111;
    localparam seg_t SEG_DASH  = 7'b1111110;  // Middle bar only

endpackage

`default_nettype wire

// ==== logic/button_conditioner.sv ====
`timescale 1ns/1ns
`default_nettype none

module button_conditioner import bulls_pkg::*; (
    input  logic clk,
    input  logic opreset,
    input  logic button,
    output logic pulse
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    level;
    logic                    level_d;

    assign level = &samples;  // Pressed once every stage saw it high

    always_ff @(posedge clk or posedge opreset) begin
        if (opreset) begin
            samples <= '0;
            level_d <= 1'b0;
            pulse   <= 1'b0;
        end else begin
            samples <= {samples[DEBOUNCE_LEN-2:0], button};
            level_d <= level;
            pulse   <= level & ~level_d;  // Rising edge only
        end
    end

endmodule

`default_nettype wire

// ==== logic/secret_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module secret_generator import bulls_pkg::*; (
    input  logic  clk,
    input  logic  opreset,
    output code_t candidate
);

    logic [15:0] lfsr;

    // Every nibble a decimal digit and no digit repeated
    function automatic logic is_legal(input code_t c);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            if (c[i] > MAX_DIGIT)
                ok = 1'b0;
            for (int j = i + 1; j < DIGITS; j++) begin
                if (c[i] == c[j])
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_ff @(posedge clk or posedge opreset) begin
        if (opreset) begin
            lfsr      <= LFSR_SEED;
            candidate <= code_t'(16'h0123);
        end else begin
            lfsr <= {lfsr[14:4],
                     lfsr[3] ^ lfsr[15],
                     lfsr[2] ^ lfsr[15],
                     lfsr[1] ^ lfsr[15],
                     lfsr[0],
                     lfsr[15]};
            if (is_legal(code_t'(lfsr)))
                candidate <= code_t'(lfsr);  // else keep last good code
        end
    end

endmodule

`default_nettype wire

// ==== logic/bulls_cows_scorer.sv ====
`timescale 1ns/1ns
`default_nettype none

module bulls_cows_scorer import bulls_pkg::*; (
    input  code_t  secret,
    input  code_t  guess,
    output score_t score
);

    always_comb begin
        logic [DIGITS-1:0] bull;
        logic [DIGITS-1:0] present;
        score = '0;
        for (int i = 0; i < DIGITS; i++) begin
            bull[i]    = (guess[i] == secret[i]);
            present[i] = 1'b0;
            for (int j = 0; j < DIGITS; j++) begin
                if (guess[i] == secret[j])
                    present[i] = 1'b1;
            end
            if (bull[i])
                score.bulls = score.bulls + 3'd1;
            else if (present[i])
                score.cows = score.cows + 3'd1;  // Secret digits are distinct
        end
    end

endmodule

`default_nettype wire

// ==== logic/game_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_controller import bulls_pkg::*; (
    input  logic        clk,
    input  logic        opreset,
    input  buttons_t    btn,
    input  digit_t      sw,
    input  code_t       candidate,
    input  score_t      score,
    output game_state_e state,
    output code_t       secret,
    output code_t       guess,
    output logic [1:0]  entered,
    output score_t      score_q,
    output logic [15:0] led
);

    logic perfect;

    assign perfect = (score_q.bulls == 3'(DIGITS));

    // Secret hidden on the title screen
    assign led = (state == title) ? 16'h0000 : secret;

    always_ff @(posedge clk or posedge opreset) begin
        if (opreset) begin
            state   <= title;
            entered <= 2'd0;
        end else begin
            case (state)
                title: begin
                    if (btn.start) begin
                        state   <= guess_entry;
                        entered <= 2'd0;
                    end
                end
                guess_entry: begin
                    if (btn.enter) begin
                        entered <= entered + 2'd1;  // Wraps to 0 after the last digit
                        if (entered == 2'(DIGITS - 1))
                            state <= check;
                    end
                end
                check: state <= decision;
                decision: begin
                    if (perfect) begin
                        if (btn.enter || btn.start)
                            state <= title;
                    end else if (btn.enter) begin
                        state <= new_round;
                    end
                end
                new_round: begin
                    state   <= guess_entry;
                    entered <= 2'd0;
                end
                default: state <= title;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        case (state)
            title: begin
                if (btn.start) begin
                    secret <= candidate;
                    guess  <= '0;
                end
            end
            guess_entry: begin
                if (btn.enter)
                    guess[entered] <= sw;
            end
            check:     score_q <= score;
            new_round: guess   <= '0;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/display_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module display_mux import bulls_pkg::*; (
    input  logic        clk,
    input  logic        opreset,
    input  game_state_e state,
    input  code_t       guess,
    input  logic [1:0]  entered,
    input  score_t      score_q,
    input  digit_t      sw,
    output logic [3:0]  anode,
    output seg_t        cathode
);

    logic [SCAN_W-1:0] scan;
    logic [1:0]        sel;
    logic [2:0]        pos;
    digit_t            shown;

    always_ff @(posedge clk or posedge opreset) begin
        if (opreset)
            scan <= '0;
        else
            scan <= scan + SCAN_W'(1);
    end

    assign sel   = scan[SCAN_W-1 -: 2];
    assign anode = ~(4'b1000 >> sel);  // Digit 0 is leftmost

    // Latest entry lands on digit 2, older ones slide left
    assign pos = {1'b0, sel} + {1'b0, entered};
    always_comb begin
        shown = '0;
        if (pos >= 3'd3)
            shown = guess[2'(pos - 3'd3)];
    end

    always_comb begin
        case (state)
            title: begin
                case (sel)
                    2'd0:    cathode = SEG_DIGIT[1];
                    2'd1:    cathode = SEG_A;
                    2'd2:    cathode = SEG_DIGIT[2];
                    default: cathode = SEG_B;
                endcase
            end
            guess_entry: begin
                if (sel == 2'd3)
                    cathode = SEG_DIGIT[sw];  // Live switches
                else
                    cathode = SEG_DIGIT[shown];
            end
            decision: begin
                case (sel)
                    2'd0:    cathode = SEG_DIGIT[digit_t'(score_q.bulls)];
                    2'd1:    cathode = SEG_A;
                    2'd2:    cathode = SEG_DIGIT[digit_t'(score_q.cows)];
                    default: cathode = SEG_B;
                endcase
            end
            check, new_round: cathode = SEG_DASH;
            default:          cathode = SEG_BLANK;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/bulls_cows_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module bulls_cows_top import bulls_pkg::*; (
    input  logic        clk,
    input  logic        opreset,
    input  logic        enterb,
    input  logic        startb,
    input  digit_t      sw,
    output logic [3:0]  anode,
    output seg_t        cathode,
    output logic [15:0] led
);

    buttons_t    btn;
    code_t       candidate;
    code_t       secret;
    code_t       guess;
    score_t      score;
    score_t      score_q;
    game_state_e state;
    logic [1:0]  entered;

    button_conditioner enter_cond_i (
        .clk     (clk),
        .opreset (opreset),
        .button  (enterb),
        .pulse   (btn.enter)
    );

    button_conditioner start_cond_i (
        .clk     (clk),
        .opreset (opreset),
        .button  (startb),
        .pulse   (btn.start)
    );

    secret_generator secret_gen_i (
        .clk       (clk),
        .opreset   (opreset),
        .candidate (candidate)
    );

    game_controller game_ctrl_i (
        .clk       (clk),
        .opreset   (opreset),
        .btn       (btn),
        .sw        (sw),
        .candidate (candidate),
        .score     (score),
        .state     (state),
        .secret    (secret),
        .guess     (guess),
        .entered   (entered),
        .score_q   (score_q),
        .led       (led)
    );

    bulls_cows_scorer scorer_i (
        .secret (secret),
        .guess  (guess),
        .score  (score)
    );

    display_mux display_i (
        .clk     (clk),
        .opreset (opreset),
        .state   (state),
        .guess   (guess),
        .entered (entered),
        .score_q (score_q),
        .sw      (sw),
        .anode   (anode),
        .cathode (cathode)
    );

endmodule

`default_nettype wire

// ==== verification/bulls_cows_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module bulls_cows_assertions import bulls_pkg::*; (
    input logic        clk,
    input logic        opreset,
    input logic [3:0]  anode,
    input logic [15:0] led,
    input game_state_e state
);

    one_digit_lit : assert property (@(posedge clk) disable iff (opreset)
        $onehot(~anode))
        else $error("anode does not select exactly one digit");

    // Secret stays hidden on the title screen
    led_dark_in_title : assert property (@(posedge clk) disable iff (opreset)
        state == title |-> led == 16'h0000)
        else $error("led not zero in title");

    check_one_cycle : assert property (@(posedge clk) disable iff (opreset)
        state == check |=> state != check)
        else $error("check state lasted more than one cycle");

endmodule

bind bulls_cows_top bulls_cows_assertions assertions_i (
    .clk     (clk),
    .opreset (opreset),
    .anode   (anode),
    .led     (led),
    .state   (state)
);

`default_nettype wire

// ==== verification/bulls_cows_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module bulls_cows_tb import bulls_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int TEST_CYCLES = 6000;           // All tests with margin
    localparam int SCAN_LIMIT  = 2 ** SCAN_W + 4;

    logic        clk;
    logic        opreset;
    logic        enterb;
    logic        startb;
    digit_t      sw;
    logic [3:0]  anode;
    seg_t        cathode;
    logic [15:0] led;
    logic [31:0] rng;

    bulls_cows_top dut_i (
        .clk     (clk),
        .opreset (opreset),
        .enterb  (enterb),
        .startb  (startb),
        .sw      (sw),
        .anode   (anode),
        .cathode (cathode),
        .led     (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic digit_t random_digit();
        rng = xorshift(rng);
        return digit_t'(rng % 32'd10);
    endfunction

    // Cows are guess slots whose digit is in the secret, minus the bulls
    function automatic score_t expected_score(input code_t secret, input code_t guess);
        score_t s;
        int     hits;
        logic   found;
        s    = '0;
        hits = 0;
        for (int i = 0; i < DIGITS; i++) begin
            found = 1'b0;
            if (guess[i] == secret[i])
                s.bulls = s.bulls + 3'd1;
            for (int j = 0; j < DIGITS; j++) begin
                if (guess[i] == secret[j])
                    found = 1'b1;
            end
            if (found)
                hits++;
        end
        s.cows = 3'(hits) - s.bulls;
        return s;
    endfunction

    task automatic apply_reset();
        opreset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        opreset = 1'b0;
    endtask

    task automatic press(input logic start_button);
        @(negedge clk);
        if (start_button)
            startb = 1'b1;
        else
            enterb = 1'b1;
        repeat (8) @(negedge clk);
        startb = 1'b0;
        enterb = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic read_digit(input int idx, output seg_t seg);
        logic [3:0] want;
        int         n;
        want           = 4'b1111;
        want[3 - idx]  = 1'b0;  // Digit 0 drives anode bit 3
        n              = 0;
        @(negedge clk);
        while (anode !== want && n < SCAN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (anode !== want) begin
            $display("The display never selected digit %0d", idx);
            $display("Result: FAILED");
            $fatal(1, "Display scan stuck");
        end
        seg = cathode;
    endtask

    task automatic check_digit(input int idx, input seg_t expected, input string what);
        seg_t got;
        read_digit(idx, got);
        assert (got == expected)
            else report_error($sformatf("%s: digit %0d shows %b, expected %b",
                                        what, idx, got, expected));
    endtask

    task automatic check_display(input seg_t d0, input seg_t d1, input seg_t d2,
                                 input seg_t d3, input string what);
        check_digit(0, d0, what);
        check_digit(1, d1, what);
        check_digit(2, d2, what);
        check_digit(3, d3, what);
    endtask

    task automatic check_led(input logic [15:0] expected, input string what);
        assert (led == expected)
            else report_error($sformatf("%s: led is %h, expected %h", what, led, expected));
    endtask

    task automatic check_secret_legal();
        code_t s;
        s = code_t'(led);
        for (int i = 0; i < DIGITS; i++) begin
            assert (s[i] <= MAX_DIGIT)
                else report_error($sformatf("secret %h has a digit above nine", led));
            for (int j = i + 1; j < DIGITS; j++) begin
                assert (s[i] != s[j])
                    else report_error($sformatf("secret %h repeats a digit", led));
            end
        end
    endtask

    task automatic enter_guess(input code_t g);
        for (int i = 0; i < DIGITS; i++) begin
            sw = g[i];
            press(1'b0);
        end
    endtask

    task automatic check_score(input code_t g, input string what);
        score_t exp;
        exp = expected_score(code_t'(led), g);
        check_display(SEG_DIGIT[digit_t'(exp.bulls)], SEG_A,
                      SEG_DIGIT[digit_t'(exp.cows)], SEG_B, what);
    endtask

    task automatic title_after_reset();
        check_led(16'h0000, "after reset");
        check_display(SEG_DIGIT[1], SEG_A, SEG_DIGIT[2], SEG_B, "title");
    endtask

    task automatic start_and_entry();
        press(1'b1);
        check_secret_legal();
        sw = 4'd7;
        check_digit(3, SEG_DIGIT[7], "live switch");
        sw = 4'd2;
        check_digit(3, SEG_DIGIT[2], "live switch");
        sw = 4'd5;
        press(1'b0);
        sw = 4'd8;
        press(1'b0);
        sw = 4'd3;
        check_display(SEG_DIGIT[0], SEG_DIGIT[5], SEG_DIGIT[8], SEG_DIGIT[3], "two entries");
        press(1'b0);
        sw = 4'd1;
        press(1'b0);
        check_score({4'd1, 4'd3, 4'd8, 4'd5}, "first score");
        press(1'b0);  // New round
    endtask

    task automatic rotated_guess_round();
        code_t secret;
        code_t g;
        secret = code_t'(led);
        for (int i = 0; i < DIGITS; i++)
            g[i] = secret[(i + 1) % DIGITS];
        enter_guess(g);
        check_display(SEG_DIGIT[0], SEG_A, SEG_DIGIT[4], SEG_B, "rotated guess");
        sw = 4'd6;
        press(1'b0);
        check_display(SEG_DIGIT[0], SEG_DIGIT[0], SEG_DIGIT[0], SEG_DIGIT[6], "new round");
        check_led(secret, "secret kept over rounds");
    endtask

    task automatic random_guess_rounds();
        code_t  g;
        score_t exp;
        repeat (4) begin
            for (int i = 0; i < DIGITS; i++)
                g[i] = random_digit();
            exp = expected_score(code_t'(led), g);
            enter_guess(g);
            check_score(g, "random guess");
            press(1'b0);
            if (exp.bulls == 3'd4)
                press(1'b1);  // Lucky win, back from the title
        end
    endtask

    task automatic perfect_guess_win();
        enter_guess(code_t'(led));
        check_display(SEG_DIGIT[4], SEG_A, SEG_DIGIT[0], SEG_B, "perfect guess");
        press(1'b1);
        check_led(16'h0000, "back at title");
        check_display(SEG_DIGIT[1], SEG_A, SEG_DIGIT[2], SEG_B, "title after win");
        press(1'b1);
        check_secret_legal();
    endtask

    task automatic reset_mid_entry();
        sw = 4'd3;
        press(1'b0);
        sw = 4'd9;
        press(1'b0);
        apply_reset();
        check_led(16'h0000, "reset during entry");
        check_display(SEG_DIGIT[1], SEG_A, SEG_DIGIT[2], SEG_B, "title after reset");
    endtask

    initial begin
        clk     = 1'b0;
        opreset = 1'b1;
        enterb  = 1'b0;
        startb  = 1'b0;
        sw      = '0;
        rng     = 32'd21;
        apply_reset();
        title_after_reset();
        start_and_entry();
        rotated_guess_round();
        random_guess_rounds();
        perfect_guess_win();
        reset_mid_entry();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/bulls_pkg.sv
logic/button_conditioner.sv
logic/secret_generator.sv
logic/bulls_cows_scorer.sv
logic/game_controller.sv
logic/display_mux.sv
logic/bulls_cows_top.sv
verification/bulls_cows_assertions.sv
verification/bulls_cows_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Bulls-and-Cows testbench with Verilator
verilator --binary --assert --timing --top-module bulls_cows_tb -f sources.f \
    -o bulls_cows_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/bulls_cows_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
[ "$status" -eq 0 ] && grep -q "Result: PASSED" sim.log || exit 1
echo "Simulation passed"
